/* rtl/aurora_pkg.sv */
// Shared widths and encodings for the 64b/66b lane.
// Imported by every RTL module and by the testbench.
`default_nettype none

package aurora_pkg;

    // block and gearbox widths
    localparam int PAYLOAD_W  = 64;
    localparam int HDR_W      = 2;
    localparam int BLOCK_W    = PAYLOAD_W + HDR_W;
    localparam int WORD_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int WORD_BEATS = WORD_W / BYTE_W;

    // sync header, only 01 and 10 are legal
    typedef enum logic [HDR_W-1:0] {
        SH_BAD0 = 2'b00,
        SH_DATA = 2'b01,
        SH_CTRL = 2'b10,
        SH_BAD3 = 2'b11
    } sync_hdr_e;

    // block sync states
    typedef enum logic {
        BS_SEARCH = 1'b0,
        BS_LOCKED = 1'b1
    } bsync_state_e;

endpackage

`default_nettype wire

/* rtl/tx_lane.sv */
// Transmit path of the lane: 66-to-32 gearbox feeding a 32-to-8 byte serialiser.
// Blocks are requested with data_next_o, bytes leave on every clk160 cycle.
`timescale 1ns/1ps
`default_nettype none

module tx_lane
    import aurora_pkg::*;
(
    input  logic                 clk160,
    input  logic                 rst,
    input  logic [PAYLOAD_W-1:0] data_i,
    input  sync_hdr_e            sync_i,
    output logic                 data_next_o,
    output logic [BYTE_W-1:0]    byte_o
);

    // buffer plus one incoming block
    localparam int CAT_W  = BLOCK_W + WORD_W;
    localparam int FILL_W = $clog2(CAT_W + 1);
    localparam int BEAT_W = $clog2(WORD_BEATS);

    logic [BEAT_W-1:0] beat_q;
    logic              slot;
    logic              need_blk;
    logic [BLOCK_W-1:0] bits_q;
    logic [FILL_W-1:0]  fill_q;
    logic [CAT_W-1:0]   cat;
    logic [FILL_W-1:0]  cat_fill;
    logic [WORD_W-1:0]  shreg_q;

    // ============================================================
    // gearbox
    // ============================================================

    // word slot on the last beat, so the first slot comes 4 cycles out of reset
    assign slot     = (beat_q == BEAT_W'(WORD_BEATS - 1));
    // top up when the buffer cannot cover a whole word
    assign need_blk = slot && (fill_q < FILL_W'(WORD_W));

    always_comb begin
        cat      = {{WORD_W{1'b0}}, bits_q};
        cat_fill = fill_q;
        if (need_blk) begin
            // header in the low bits so it goes out first
            cat      = cat | ({{WORD_W{1'b0}}, data_i, sync_i} << fill_q);
            cat_fill = fill_q + FILL_W'(BLOCK_W);
        end
    end

    // capture happens in the pulse cycle itself
    assign data_next_o = need_blk;

    always_ff @(posedge clk160) begin
        if (rst) begin
            beat_q  <= '0;
            fill_q  <= '0;
            bits_q  <= '0;
            shreg_q <= '0;
        end else begin
            if (slot) begin
                beat_q <= '0;
            end else begin
                beat_q <= beat_q + 1'b1;
            end

            if (slot) begin
                // oldest 32 bits go to the serialiser, rest stays buffered
                bits_q  <= cat[CAT_W-1:WORD_W];
                fill_q  <= cat_fill - FILL_W'(WORD_W);
                shreg_q <= cat[WORD_W-1:0];
            end else begin
                // serialiser, LSB byte first
                shreg_q <= shreg_q >> BYTE_W;
            end
        end
    end

    // ============================================================
    // line byte
    // ============================================================
    assign byte_o = shreg_q[BYTE_W-1:0];

    // slots are WORD_BEATS apart, so requests can never run back to back
    a_no_double_next: assert property (
        @(posedge clk160) disable iff (rst)
        data_next_o |=> !data_next_o
    ) else $error("tx_lane: data_next_o high in consecutive cycles");

endmodule

`default_nettype wire

/* rtl/rx_gearbox.sv */
// Receive path of the lane: bytes to 32-bit words, words to 66-bit blocks.
// A slip pulse drops one buffered bit to move the block boundary.
`timescale 1ns/1ps
`default_nettype none

module rx_gearbox
    import aurora_pkg::*;
(
    input  logic               clk160,
    input  logic               rst,
    input  logic [BYTE_W-1:0]  byte_i,
    input  logic               slip_i,
    output logic [BLOCK_W-1:0] block_o,
    output logic               block_valid_o
);

    // leftover below one block plus one word
    localparam int CAT_W  = BLOCK_W + WORD_W;
    localparam int FILL_W = $clog2(CAT_W + 1);
    localparam int BEAT_W = $clog2(WORD_BEATS);

    logic [BEAT_W-1:0] beat_q;
    logic [WORD_W-1:0] word_q;
    logic [WORD_W-1:0] word_full;
    logic              word_done;
    logic [CAT_W-1:0]  buf_q;
    logic [FILL_W-1:0] fill_q;
    logic              emit;
    logic [CAT_W-1:0]  rem_buf;
    logic [FILL_W-1:0] rem_fill;
    logic [CAT_W-1:0]  cat_buf;
    logic [FILL_W-1:0] cat_fill;
    logic              slip_pend_q;
    logic              slip_req;
    logic              slip_go;

    // ============================================================
    // byte to word
    // ============================================================
    assign word_done = (beat_q == BEAT_W'(WORD_BEATS - 1));
    // first byte received ends up in the low byte
    assign word_full = {byte_i, word_q[WORD_W-1:BYTE_W]};

    // ============================================================
    // word to block
    // ============================================================
    assign emit = (fill_q >= FILL_W'(BLOCK_W));

    always_comb begin
        // take out the block being emitted
        rem_buf  = buf_q;
        rem_fill = fill_q;
        if (emit) begin
            rem_buf  = buf_q >> BLOCK_W;
            rem_fill = fill_q - FILL_W'(BLOCK_W);
        end
        // append the new word above what is left
        cat_buf  = rem_buf;
        cat_fill = rem_fill;
        if (word_done) begin
            cat_buf  = rem_buf | ({{BLOCK_W{1'b0}}, word_full} << rem_fill);
            cat_fill = rem_fill + FILL_W'(WORD_W);
        end
        // an empty buffer holds the slip until a bit is there to drop
        slip_req = slip_i || slip_pend_q;
        slip_go  = slip_req && (cat_fill != '0);
    end

    always_ff @(posedge clk160) begin
        if (rst) begin
            beat_q        <= '0;
            buf_q         <= '0;
            fill_q        <= '0;
            slip_pend_q   <= 1'b0;
            block_valid_o <= 1'b0;
        end else begin
            if (word_done) begin
                beat_q <= '0;
            end else begin
                beat_q <= beat_q + 1'b1;
            end
            if (slip_go) begin
                buf_q  <= cat_buf >> 1;
                fill_q <= cat_fill - 1'b1;
            end else begin
                buf_q  <= cat_buf;
                fill_q <= cat_fill;
            end
            slip_pend_q   <= slip_req && !slip_go;
            block_valid_o <= emit;
        end
    end

    // payload path
    always_ff @(posedge clk160) begin
        word_q <= word_full;
        if (emit) begin
            block_o <= buf_q[BLOCK_W-1:0];
        end
    end

    // one word per 4 cycles is less than one block, so blocks never pile up
    a_no_double_valid: assert property (
        @(posedge clk160) disable iff (rst)
        block_valid_o |=> !block_valid_o
    ) else $error("rx_gearbox: block_valid_o high in consecutive cycles");

endmodule

`default_nettype wire

/* rtl/block_sync.sv */
// Block synchroniser: checks sync headers, declares lock and asks for slips.
// Fed by rx_gearbox blocks, slip_o goes straight back to the gearbox.
`timescale 1ns/1ps
`default_nettype none

module block_sync
    import aurora_pkg::*;
#(
    parameter int SH_CNT_MAX     = 64,
    parameter int SH_INVALID_MAX = 16
) (
    input  logic      clk160,
    input  logic      rst,
    input  sync_hdr_e hdr_i,
    input  logic      hdr_valid_i,
    output logic      slip_o,
    output logic      lock_o
);

    localparam int CNT_W = $clog2(SH_CNT_MAX + 1);
    localparam int INV_W = $clog2(SH_INVALID_MAX + 1);

    bsync_state_e     state_q;
    logic [CNT_W-1:0] sh_cnt_q;
    logic [INV_W-1:0] inv_cnt_q;
    logic [INV_W-1:0] inv_cnt_nxt;
    logic             skip_q;
    logic             hdr_ok;
    logic             window_end;

    assign hdr_ok      = (hdr_i == SH_DATA) || (hdr_i == SH_CTRL);
    assign window_end  = (sh_cnt_q == CNT_W'(SH_CNT_MAX - 1));
    assign inv_cnt_nxt = inv_cnt_q + INV_W'(!hdr_ok);

    // ============================================================
    // lock FSM
    // ============================================================
    always_ff @(posedge clk160) begin
        if (rst) begin
            state_q   <= BS_SEARCH;
            sh_cnt_q  <= '0;
            inv_cnt_q <= '0;
            skip_q    <= 1'b0;
            slip_o    <= 1'b0;
        end else begin
            slip_o <= 1'b0;
            if (hdr_valid_i) begin
                if (skip_q) begin
                    // block right after a slip may span the old boundary
                    skip_q <= 1'b0;
                end else begin
                    case (state_q)
                        BS_SEARCH: begin
                            if (!hdr_ok) begin
                                slip_o   <= 1'b1;
                                skip_q   <= 1'b1;
                                sh_cnt_q <= '0;
                            end else if (window_end) begin
                                // full run of good headers
                                state_q   <= BS_LOCKED;
                                sh_cnt_q  <= '0;
                                inv_cnt_q <= '0;
                            end else begin
                                sh_cnt_q <= sh_cnt_q + 1'b1;
                            end
                        end
                        BS_LOCKED: begin
                            if (inv_cnt_nxt == INV_W'(SH_INVALID_MAX)) begin
                                // too many bad headers in this window
                                state_q   <= BS_SEARCH;
                                slip_o    <= 1'b1;
                                skip_q    <= 1'b1;
                                sh_cnt_q  <= '0;
                                inv_cnt_q <= '0;
                            end else if (window_end) begin
                                sh_cnt_q  <= '0;
                                inv_cnt_q <= '0;
                            end else begin
                                sh_cnt_q  <= sh_cnt_q + 1'b1;
                                inv_cnt_q <= inv_cnt_nxt;
                            end
                        end
                        default: state_q <= BS_SEARCH;
                    endcase
                end
            end
        end
    end

    assign lock_o = (state_q == BS_LOCKED);

    // a slip is only ever issued while searching
    a_no_slip_locked: assert property (
        @(posedge clk160) disable iff (rst)
        slip_o |-> (state_q == BS_SEARCH)
    ) else $error("block_sync: slip while locked");

endmodule

`default_nettype wire

/* rtl/aurora_lane.sv */
// Top level of one 64b/66b lane on clk160: transmit gearbox, receive gearbox, block sync.
// Payload and header come out only while the lane is locked.
`timescale 1ns/1ps
`default_nettype none

module aurora_lane
    import aurora_pkg::*;
#(
    parameter int SH_CNT_MAX     = 64,
    parameter int SH_INVALID_MAX = 16
) (
    input  logic                 clk160,
    input  logic                 rst,
    // transmit
    input  logic [PAYLOAD_W-1:0] tx_data_i,
    input  sync_hdr_e            tx_sync_i,
    output logic                 tx_data_next_o,
    output logic [BYTE_W-1:0]    tx_byte_o,
    // receive
    input  logic [BYTE_W-1:0]    rx_byte_i,
    output logic [PAYLOAD_W-1:0] rx_data_o,
    output sync_hdr_e            rx_sync_o,
    output logic                 rx_valid_o,
    output logic                 block_lock_o
);

    logic [BLOCK_W-1:0] rx_block;
    logic               rx_block_valid;
    logic               slip;

    tx_lane u_tx_lane (
        .clk160      (clk160),
        .rst         (rst),
        .data_i      (tx_data_i),
        .sync_i      (tx_sync_i),
        .data_next_o (tx_data_next_o),
        .byte_o      (tx_byte_o)
    );

    rx_gearbox u_rx_gearbox (
        .clk160        (clk160),
        .rst           (rst),
        .byte_i        (rx_byte_i),
        .slip_i        (slip),
        .block_o       (rx_block),
        .block_valid_o (rx_block_valid)
    );

    // header sits in the low bits of the block
    assign rx_sync_o = sync_hdr_e'(rx_block[HDR_W-1:0]);
    assign rx_data_o = rx_block[BLOCK_W-1:HDR_W];

    block_sync #(
        .SH_CNT_MAX     (SH_CNT_MAX),
        .SH_INVALID_MAX (SH_INVALID_MAX)
    ) u_block_sync (
        .clk160      (clk160),
        .rst         (rst),
        .hdr_i       (rx_sync_o),
        .hdr_valid_i (rx_block_valid),
        .slip_o      (slip),
        .lock_o      (block_lock_o)
    );

    // deliver only aligned blocks
    assign rx_valid_o = rx_block_valid && block_lock_o;

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
// Testbench clock and synchronous reset source for the lane.
// A request seen on a rising edge restarts a reset of RST_CYCLES cycles.
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_NS    = 50,
    parameter int RST_CYCLES = 8
) (
    input  logic rst_req_i,
    output logic clk_o,
    output logic rst_o
);

    int   left;
    logic req;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        left  = RST_CYCLES;
    end

    always #(HALF_NS) clk_o = ~clk_o;

    // request sampled on the edge, reset driven just after it
    always @(posedge clk_o) begin
        req = rst_req_i;
        #1;
        if (req) begin
            left = RST_CYCLES;
        end
        rst_o = (left != 0);
        if (left != 0) begin
            left = left - 1;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_aurora_lane.sv */
// Loopback testbench for one lane: each table row sets the line delay and a bad-header burst.
// Sent blocks are queued and compared in order with the blocks the receiver delivers.
`timescale 1ns/1ps
`default_nettype none

module tb_aurora_lane
    import aurora_pkg::*;
();

    localparam int RST_CYCLES   = 8;
    localparam int SH_CNT_MAX   = 64;
    localparam int LOCK_TIMEOUT = 66 * 80 * 9;
    // 33 words carry exactly 16 blocks
    localparam int RATE_WINDOW  = 33 * WORD_BEATS;
    localparam int RATE_PULSES  = 33 * WORD_W / BLOCK_W;
    localparam int NUM_ROWS     = 4;

    typedef struct packed {
        logic [1:0] delay;
        logic [7:0] bad_blocks;
        logic       keep_lock;
    } row_t;

    logic                 clk160;
    logic                 rst;
    logic                 rst_req;
    logic [PAYLOAD_W-1:0] tx_data_i;
    sync_hdr_e            tx_sync_i;
    logic                 tx_data_next_o;
    logic [BYTE_W-1:0]    tx_byte_o;
    logic [BYTE_W-1:0]    rx_byte_i;
    logic [PAYLOAD_W-1:0] rx_data_o;
    sync_hdr_e            rx_sync_o;
    logic                 rx_valid_o;
    logic                 block_lock_o;

    row_t               rows [NUM_ROWS];
    logic [BLOCK_W-1:0] exp_q [$];
    logic [BYTE_W-1:0]  line_q [4];
    logic [15:0]        lfsr_q;
    int                 row_delay;
    int                 bad_left;
    int                 rx_cnt;
    bit                 synced;
    bit                 take;
    bit                 rate_on;
    int                 rate_cyc;
    int                 rate_cnt;
    int                 passes;
    int                 errors;
    bit                 timed_out;

    clock_gen #(.HALF_NS(50), .RST_CYCLES(RST_CYCLES)) u_clock_gen (
        .rst_req_i (rst_req),
        .clk_o     (clk160),
        .rst_o     (rst)
    );

    aurora_lane #(.SH_CNT_MAX(SH_CNT_MAX), .SH_INVALID_MAX(16)) u_dut (
        .clk160         (clk160),
        .rst            (rst),
        .tx_data_i      (tx_data_i),
        .tx_sync_i      (tx_sync_i),
        .tx_data_next_o (tx_data_next_o),
        .tx_byte_o      (tx_byte_o),
        .rx_byte_i      (rx_byte_i),
        .rx_data_o      (rx_data_o),
        .rx_sync_o      (rx_sync_o),
        .rx_valid_o     (rx_valid_o),
        .block_lock_o   (block_lock_o)
    );

    // ============================================================
    // stimulus source
    // ============================================================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        b      = lfsr_q[15];
        lfsr_q = lfsr_step(lfsr_q);
    endtask

    // next block on the tx inputs, held until data_next takes it
    task automatic load_block();
        logic [PAYLOAD_W-1:0] data;
        logic                 b;
        int                   i;
        for (i = 0; i < PAYLOAD_W; i++) begin
            take_bit(b);
            data[i] = b;
        end
        take_bit(b);
        tx_data_i = data;
        if (bad_left > 0) begin
            tx_sync_i = SH_BAD0;
            bad_left--;
        end else begin
            tx_sync_i = b ? SH_CTRL : SH_DATA;
        end
    endtask

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic check_block(input logic [PAYLOAD_W-1:0] exp_data, input sync_hdr_e exp_hdr);
        if (rx_data_o !== exp_data || rx_sync_o !== exp_hdr) begin
            $display("Error %0t: rx block %h/%s, expected %h/%s", $time,
                     rx_data_o, rx_sync_o.name(), exp_data, exp_hdr.name());
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_lock(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("Error %0t: %s is %b, expected %b", $time, what, act, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_count(input int act, input int exp, input string what);
        if (act != exp) begin
            $display("Error %0t: %s is %0d, expected %0d", $time, what, act, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    // first block after lock may come from anywhere in the queue
    task automatic match_rx_block();
        logic [BLOCK_W-1:0] e;
        bit                 found;
        found = 1'b0;
        if (!synced) begin
            while (exp_q.size() > 0 && !found) begin
                e     = exp_q.pop_front();
                found = (e == {rx_data_o, rx_sync_o});
            end
            synced = found;
            if (found) begin
                passes++;
            end
        end else if (exp_q.size() > 0) begin
            e     = exp_q.pop_front();
            found = 1'b1;
            check_block(e[BLOCK_W-1:HDR_W], sync_hdr_e'(e[HDR_W-1:0]));
        end
        if (!found) begin
            $display("Error %0t: received block %h was never sent", $time, rx_data_o);
            errors++;
        end
    endtask

    // ============================================================
    // loopback line and monitors
    // ============================================================
    always @(posedge clk160) begin
        int i;
        #1;
        for (i = 3; i > 0; i--) begin
            line_q[i] = line_q[i-1];
        end
        line_q[0] = tx_byte_o;
        rx_byte_i = line_q[row_delay];
        if (take) begin
            load_block();
        end
    end

    // tx side queues captured blocks and counts requests per window
    always @(negedge clk160) begin
        take = 1'b0;
        if (rst) begin
            rate_on  = 1'b0;
            rate_cyc = 0;
            rate_cnt = 0;
        end else begin
            if (tx_data_next_o) begin
                exp_q.push_back({tx_data_i, tx_sync_i});
                take    = 1'b1;
                rate_on = 1'b1;
                rate_cnt++;
            end
            if (rate_on) begin
                rate_cyc++;
                if (rate_cyc == RATE_WINDOW) begin
                    check_count(rate_cnt, RATE_PULSES, "data_next pulses per window");
                    rate_cyc = 0;
                    rate_cnt = 0;
                end
            end
        end
    end

    // rx block count restarts whenever lock drops
    always @(negedge clk160) begin
        if (rst || !block_lock_o) begin
            synced = 1'b0;
            rx_cnt = 0;
        end else if (rx_valid_o) begin
            rx_cnt++;
            match_rx_block();
        end
    end

    // ============================================================
    // sequencing
    // ============================================================
    task automatic apply_reset(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        @(posedge clk160);
        #1 rst_req = 1'b1;
        @(posedge clk160);
        #1 rst_req = 1'b0;
        // synchronous reset acts from the next edge
        @(posedge clk160);
        // outputs low through reset and the cycle after
        do begin
            @(negedge clk160);
            check_lock(block_lock_o, 1'b0, "block_lock_o in reset");
            check_lock(rx_valid_o, 1'b0, "rx_valid_o in reset");
            check_lock(tx_data_next_o, 1'b0, "tx_data_next_o in reset");
            n++;
        end while (rst && n < 4 * RST_CYCLES);
        if (rst) begin
            $display("reset did not release within %0d cycles", 4 * RST_CYCLES);
        end else begin
            @(posedge clk160);
            #1;
            exp_q.delete();
            bad_left = 0;
            load_block();
            ok = 1'b1;
        end
    endtask

    task automatic wait_lock(input logic level, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < LOCK_TIMEOUT && !ok; n++) begin
            @(negedge clk160);
            ok = (block_lock_o == level);
        end
        if (!ok) begin
            $display("timeout waiting for block_lock_o to become %0b", level);
        end
    endtask

    // with hold set the lock must stay high for the whole wait
    task automatic wait_blocks(input int count, input bit hold, output bit ok);
        int n;
        bit held;
        ok   = 1'b0;
        held = hold;
        for (n = 0; n < 10 * count + 100 && !ok; n++) begin
            @(negedge clk160);
            if (held && !block_lock_o) begin
                check_lock(block_lock_o, 1'b1, "block_lock_o during bad headers");
                held = 1'b0;
            end
            ok = (rx_cnt >= count);
        end
        if (!ok) begin
            $display("timeout waiting for %0d received blocks", count);
        end
    endtask

    task automatic run_row(input row_t row, output bit ok);
        bit w;
        ok        = 1'b0;
        row_delay = int'(row.delay);
        apply_reset(w);
        if (!w) return;
        wait_lock(1'b1, w);
        if (!w) return;
        // bad burst lands early in the second header window
        wait_blocks(SH_CNT_MAX + 8, 1'b0, w);
        if (!w) return;
        bad_left = int'(row.bad_blocks);
        if (row.keep_lock) begin
            wait_blocks(2 * SH_CNT_MAX + 12, 1'b1, w);
            if (!w) return;
            check_lock(block_lock_o, 1'b1, "block_lock_o after bad headers");
        end else begin
            wait_lock(1'b0, w);
            if (!w) return;
            wait_lock(1'b1, w);
            if (!w) return;
            wait_blocks(SH_CNT_MAX, 1'b1, w);
            if (!w) return;
        end
        ok = 1'b1;
    endtask

    initial begin
        int r;
        bit ok;
        rst_req   = 1'b0;
        tx_data_i = '0;
        tx_sync_i = SH_DATA;
        rx_byte_i = '0;
        lfsr_q    = 16'd8;
        for (r = 0; r < 4; r++) begin
            line_q[r] = '0;
        end
        // delay, bad headers, lock kept
        rows[0] = '{2'd0, 8'd0, 1'b1};
        rows[1] = '{2'd1, 8'd8, 1'b1};
        rows[2] = '{2'd2, 8'd20, 1'b0};
        rows[3] = '{2'd3, 8'd20, 1'b0};
        for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(rows[r], ok);
            timed_out = !ok;
            $display("row %0d: delay %0d, %0d bad headers, %0d errors so far",
                     r, rows[r].delay, rows[r].bad_blocks, errors);
        end
        $display("checks passed %0d, failed %0d", passes, errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* aurora_lane.f */
rtl/aurora_pkg.sv
rtl/tx_lane.sv
rtl/rx_gearbox.sv
rtl/block_sync.sv
rtl/aurora_lane.sv
tb/clock_gen.sv
tb/tb_aurora_lane.sv

/* Makefile */
# Verilator build and run of the lane testbench
SIM := obj_dir/Vtb_aurora_lane

$(SIM): aurora_lane.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_aurora_lane \
		-f aurora_lane.f -o Vtb_aurora_lane

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@! grep -q "test failed" sim.log && grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
